/* rv_pkg.sv */
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000; // first fetch

    // major opcodes, instr[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SRL    = 4'd3,
        ALU_SRA    = 4'd4,
        ALU_AND    = 4'd5,
        ALU_OR     = 4'd6,
        ALU_XOR    = 4'd7,
        ALU_PASS_B = 4'd8   // lui
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } branch_t;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_type_t;

    // register write source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_t;

endpackage

/* alu.sv */
`timescale 1ns/1ps

module alu import rv_pkg::*; (
    input  word_t   op_a,
    input  word_t   op_b,
    input  alu_op_t alu_op,
    output word_t   result
);
    logic [4:0] shamt;

    assign shamt = op_b[4:0]; // low five bits only

    always_comb begin
        case (alu_op)
            ALU_ADD:    result = op_a + op_b;
            ALU_SUB:    result = op_a - op_b;
            ALU_SLL:    result = op_a << shamt;
            ALU_SRL:    result = op_a >> shamt;
            ALU_SRA:    result = word_t'($signed(op_a) >>> shamt);
            ALU_AND:    result = op_a & op_b;
            ALU_OR:     result = op_a | op_b;
            ALU_XOR:    result = op_a ^ op_b;
            ALU_PASS_B: result = op_b;
            default:    result = '0;
        endcase
    end

endmodule

/* branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import rv_pkg::*; (
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  branch_t branch_kind,
    output logic    take
);
    logic eq;
    logic lt;
    logic ltu;

    assign eq  = (rs1_data == rs2_data);
    assign lt  = ($signed(rs1_data) < $signed(rs2_data));
    assign ltu = (rs1_data < rs2_data); // unsigned compare

    always_comb begin
        case (branch_kind)
            BR_EQ:   take = eq;
            BR_NE:   take = !eq;
            BR_LT:   take = lt;
            BR_GE:   take = !lt;
            BR_LTU:  take = ltu;
            BR_GEU:  take = !ltu;
            default: take = 1'b0; // BR_NONE
        endcase
    end

endmodule

/* imm_gen.sv */
`timescale 1ns/1ps

module imm_gen import rv_pkg::*; (
    input  word_t     instr,
    input  imm_type_t imm_type,
    output word_t     imm
);

    always_comb begin
        case (imm_type)
            IMM_I: imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offset, bit 0 always zero
            IMM_B: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            IMM_U: imm = {instr[31:12], 12'h000};
            IMM_J: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import rv_pkg::*; (
    input  word_t     instr,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output alu_op_t   alu_op,
    output branch_t   branch_kind,
    output imm_type_t imm_type,
    output logic      alu_src_imm,
    output logic      alu_src_pc,
    output logic      reg_we,
    output logic      mem_we,
    output logic      jump,
    output logic      jump_reg,
    output wb_sel_t   wb_sel
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode   = instr[6:0];
    assign funct3   = instr[14:12];
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];
    assign rd_addr  = instr[11:7];

    always_comb begin
        // no-op unless a case below says otherwise
        alu_op      = ALU_ADD;
        branch_kind = BR_NONE;
        imm_type    = IMM_I;
        alu_src_imm = 1'b0;
        alu_src_pc  = 1'b0;
        reg_we      = 1'b0;
        mem_we      = 1'b0;
        jump        = 1'b0;
        jump_reg    = 1'b0;
        wb_sel      = WB_ALU;
        case (opcode)
            OPC_OP: begin
                reg_we = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'b000}: alu_op = ALU_ADD;
                    {7'h20, 3'b000}: alu_op = ALU_SUB;
                    {7'h00, 3'b001}: alu_op = ALU_SLL;
                    {7'h00, 3'b100}: alu_op = ALU_XOR;
                    {7'h00, 3'b101}: alu_op = ALU_SRL;
                    {7'h20, 3'b101}: alu_op = ALU_SRA;
                    {7'h00, 3'b110}: alu_op = ALU_OR;
                    {7'h00, 3'b111}: alu_op = ALU_AND;
                    default:         reg_we = 1'b0; // slt, sltu not kept
                endcase
            end
            OPC_OP_IMM: begin
                reg_we      = 1'b1;
                alu_src_imm = 1'b1;
                case (funct3)
                    3'b000: alu_op = ALU_ADD;
                    3'b100: alu_op = ALU_XOR;
                    3'b110: alu_op = ALU_OR;
                    3'b111: alu_op = ALU_AND;
                    3'b001: begin
                        if (funct7 == 7'h00) alu_op = ALU_SLL;
                        else reg_we = 1'b0;
                    end
                    3'b101: begin
                        if (funct7 == 7'h00) alu_op = ALU_SRL;
                        else if (funct7 == 7'h20) alu_op = ALU_SRA;
                        else reg_we = 1'b0;
                    end
                    default: reg_we = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                if (funct3 == 3'b010) begin // lw only
                    reg_we      = 1'b1;
                    alu_src_imm = 1'b1;
                    wb_sel      = WB_MEM;
                end
            end
            OPC_STORE: begin
                imm_type = IMM_S;
                if (funct3 == 3'b010) begin // sw only
                    mem_we      = 1'b1;
                    alu_src_imm = 1'b1;
                end
            end
            OPC_BRANCH: begin
                imm_type = IMM_B;
                case (funct3)
                    3'b000:  branch_kind = BR_EQ;
                    3'b001:  branch_kind = BR_NE;
                    3'b100:  branch_kind = BR_LT;
                    3'b101:  branch_kind = BR_GE;
                    3'b110:  branch_kind = BR_LTU;
                    3'b111:  branch_kind = BR_GEU;
                    default: branch_kind = BR_NONE;
                endcase
            end
            OPC_LUI: begin
                reg_we      = 1'b1;
                alu_src_imm = 1'b1;
                imm_type    = IMM_U;
                alu_op      = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                reg_we      = 1'b1;
                alu_src_imm = 1'b1;
                alu_src_pc  = 1'b1;
                imm_type    = IMM_U;
            end
            OPC_JAL: begin
                reg_we   = 1'b1;
                jump     = 1'b1;
                imm_type = IMM_J;
                wb_sel   = WB_LINK;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    reg_we   = 1'b1;
                    jump_reg = 1'b1;
                    wb_sel   = WB_LINK;
                end
            end
            default: ;
        endcase
    end

endmodule

/* register_file.sv */
`timescale 1ns/1ps

module register_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  reg_addr_t rd_addr,
    input  logic      we,
    input  word_t     wdata,
    output word_t     rs1_data,
    output word_t     rs2_data
);
    word_t regs [NUM_REGS];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != '0) begin // x0 stays zero
            regs[rd_addr] <= wdata;
        end
    end

    // combinational reads, new value visible after the edge
    assign rs1_data = regs[rs1_addr];
    assign rs2_data = regs[rs2_addr];

endmodule

/* pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  word_t imm,
    input  word_t rs1_data,
    input  logic  take,
    input  logic  jump,
    input  logic  jump_reg,
    output word_t pc,
    output word_t link_addr
);
    word_t pc_plus_4;
    word_t reg_target;
    word_t next_pc;

    assign pc_plus_4  = pc + 32'd4;
    assign reg_target = (rs1_data + imm) & ~32'd1; // jalr clears bit 0
    assign link_addr  = pc_plus_4;

    always_comb begin
        if (jump_reg)
            next_pc = reg_target;
        else if (take || jump)
            next_pc = pc + imm; // branch or jal
        else
            next_pc = pc_plus_4;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output word_t imem_addr,
    input  word_t imem_data,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    input  word_t dmem_rdata
);
    reg_addr_t rs1_addr, rs2_addr, rd_addr;
    alu_op_t   alu_op;
    branch_t   branch_kind;
    imm_type_t imm_type;
    wb_sel_t   wb_sel;
    logic      alu_src_imm, alu_src_pc;
    logic      reg_we, mem_we;
    logic      jump, jump_reg;
    logic      take;
    word_t     imm;
    word_t     rs1_data, rs2_data;
    word_t     op_a, op_b;
    word_t     alu_result;
    word_t     pc, link_addr;
    word_t     wb_data;

    inst_decoder i_inst_decoder (
        .instr      (imem_data),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rd_addr    (rd_addr),
        .alu_op     (alu_op),
        .branch_kind(branch_kind),
        .imm_type   (imm_type),
        .alu_src_imm(alu_src_imm),
        .alu_src_pc (alu_src_pc),
        .reg_we     (reg_we),
        .mem_we     (mem_we),
        .jump       (jump),
        .jump_reg   (jump_reg),
        .wb_sel     (wb_sel)
    );

    imm_gen i_imm_gen (.instr(imem_data), .imm_type(imm_type), .imm(imm));

    register_file i_register_file (
        .clk     (clk),
        .rst     (rst),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rd_addr (rd_addr),
        .we      (reg_we),
        .wdata   (wb_data),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data)
    );

    assign op_a = alu_src_pc ? pc : rs1_data;   // auipc
    assign op_b = alu_src_imm ? imm : rs2_data;

    alu i_alu (.op_a(op_a), .op_b(op_b), .alu_op(alu_op), .result(alu_result));

    branch_unit i_branch_unit (
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .branch_kind(branch_kind),
        .take       (take)
    );

    pc_unit i_pc_unit (
        .clk      (clk),
        .rst      (rst),
        .imm      (imm),
        .rs1_data (rs1_data),
        .take     (take),
        .jump     (jump),
        .jump_reg (jump_reg),
        .pc       (pc),
        .link_addr(link_addr)
    );

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = dmem_rdata;
            WB_LINK: wb_data = link_addr;
            default: wb_data = alu_result;
        endcase
    end

    assign imem_addr  = pc;
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = mem_we;

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b1; // released just after the edge
    end

endmodule

/* rv_core_assertions.sv */
`timescale 1ns/1ps

module rv_core_assertions import rv_pkg::*; (
    input logic  clk,
    input logic  rst,
    input word_t imem_addr,
    input word_t dmem_addr,
    input logic  dmem_we
);
    logic run_q; // high from the second cycle after reset

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            run_q <= 1'b0;
        else
            run_q <= 1'b1;
    end

    imem_aligned: assert property (@(posedge clk) disable iff (!rst) imem_addr[1:0] == 2'b00)
        else $error("fetch address %h not word aligned", imem_addr);

    first_fetch: assert property (@(posedge clk) disable iff (!rst) !run_q |-> imem_addr == RESET_PC)
        else $error("first fetch after reset at %h", imem_addr);

    dmem_aligned: assert property (@(posedge clk) disable iff (!rst)
                                   dmem_we |-> dmem_addr[1:0] == 2'b00)
        else $error("store address %h not word aligned", dmem_addr);

    we_known: assert property (@(posedge clk) disable iff (!rst) !$isunknown(dmem_we))
        else $error("dmem_we unknown");

endmodule

bind rv_core rv_core_assertions i_rv_core_assertions (.*);

/* rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();
    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_CYCLES      = 300;
    localparam int WATCHDOG_CYCLES = 330;
    localparam int MEM_WORDS       = 256;

    logic  clk;
    logic  rst;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    word_t imem [MEM_WORDS];
    word_t dmem [MEM_WORDS];

    // model state
    word_t m_pc;
    word_t m_regs [NUM_REGS];
    word_t m_mem [MEM_WORDS];

    int seed = 26;
    int pc_errors;
    int store_errors;
    int other_errors;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) i_tb_clock_gen (
        .clk(clk),
        .rst(rst)
    );

    rv_core i_rv_core (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .dmem_addr (dmem_addr),
        .dmem_wdata(dmem_wdata),
        .dmem_we   (dmem_we),
        .dmem_rdata(dmem_rdata)
    );

    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    always @(posedge clk) begin
        if (rst && dmem_we)
            dmem[dmem_addr[9:2]] <= dmem_wdata;
    end

    // executes one instruction on the model state
    function automatic void ref_step(input word_t ins, output logic st_en,
                                     output word_t st_addr, output word_t st_data);
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [4:0] rd;
        logic       wr;
        logic       tk;
        word_t      a, b, ea, res, nxt;
        word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
        opc   = ins[6:0];
        f3    = ins[14:12];
        f7    = ins[31:25];
        rd    = ins[11:7];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt     = m_pc + 4;
        wr      = 1'b0;
        tk      = 1'b0;
        res     = '0;
        st_en   = 1'b0;
        st_addr = '0;
        st_data = '0;
        case (opc)
            7'h33: begin
                wr = (f7 == 7'h00 && f3 != 3'd2 && f3 != 3'd3) ||
                     (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                case (f3)
                    3'd0: res = f7[5] ? a - b : a + b;
                    3'd1: res = a << b[4:0];
                    3'd4: res = a ^ b;
                    3'd5: res = f7[5] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'd6: res = a | b;
                    3'd7: res = a & b;
                    default: res = '0;
                endcase
            end
            7'h13: begin
                wr = 1'b1;
                case (f3)
                    3'd0: res = a + imm_i;
                    3'd4: res = a ^ imm_i;
                    3'd6: res = a | imm_i;
                    3'd7: res = a & imm_i;
                    3'd1: begin
                        res = a << ins[24:20];
                        wr  = (f7 == 7'h00);
                    end
                    3'd5: begin
                        res = f7[5] ? word_t'($signed(a) >>> ins[24:20]) : a >> ins[24:20];
                        wr  = (f7 == 7'h00 || f7 == 7'h20);
                    end
                    default: wr = 1'b0; // slti, sltiu dropped
                endcase
            end
            7'h03: begin
                ea  = a + imm_i;
                wr  = (f3 == 3'd2);
                res = m_mem[ea[9:2]];
            end
            7'h23: begin
                if (f3 == 3'd2) begin
                    st_en   = 1'b1;
                    st_addr = a + imm_s;
                    st_data = b;
                    m_mem[st_addr[9:2]] = b;
                end
            end
            7'h63: begin
                case (f3)
                    3'd0: tk = (a == b);
                    3'd1: tk = (a != b);
                    3'd4: tk = ($signed(a) < $signed(b));
                    3'd5: tk = ($signed(a) >= $signed(b));
                    3'd6: tk = (a < b);
                    3'd7: tk = (a >= b);
                    default: tk = 1'b0;
                endcase
                if (tk)
                    nxt = m_pc + imm_b;
            end
            7'h37: begin
                wr  = 1'b1;
                res = imm_u;
            end
            7'h17: begin
                wr  = 1'b1;
                res = m_pc + imm_u;
            end
            7'h6f: begin
                wr  = 1'b1;
                res = m_pc + 4;
                nxt = m_pc + imm_j;
            end
            7'h67: begin
                if (f3 == 3'd0) begin
                    wr  = 1'b1;
                    res = m_pc + 4;
                    nxt = (a + imm_i) & ~32'd1;
                end
            end
            default: ; // unknown opcode is a no-op
        endcase
        if (wr && rd != 5'd0)
            m_regs[rd] = res;
        m_pc = nxt;
    endfunction

    task automatic check_pc(input word_t got, input word_t exp);
        if (got !== exp) begin
            pc_errors++;
            $display("[FAIL] %0d ns: fetch address %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_store(input word_t got_addr, input word_t got_data,
                               input word_t exp_addr, input word_t exp_data);
        if (got_addr !== exp_addr || got_data !== exp_data) begin
            store_errors++;
            $display("[FAIL] %0d ns: store %h to %h, expected %h to %h",
                     $time, got_data, got_addr, exp_data, exp_addr);
        end
    endtask

    initial begin
        logic  st_en;
        word_t st_addr;
        word_t st_data;
        pc_errors    = 0;
        store_errors = 0;
        other_errors = 0;
        $readmemh("rv_core_prog.hex", imem);
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < 16)
                dmem[i] = $random(seed);
            else
                dmem[i] = (i * 32'h0101_0101) ^ 32'h5a5a_0000;
            if (i < 2)
                dmem[i][31] = 1'b1; // negative operands so sra and srl differ
            m_mem[i] = dmem[i];
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            m_regs[i] = '0;
        end
        m_pc = RESET_PC;
        wait (rst === 1'b1);
        repeat (NUM_CYCLES) begin
            @(negedge clk); // outputs settled mid cycle
            check_pc(imem_addr, m_pc);
            ref_step(imem[m_pc[9:2]], st_en, st_addr, st_data);
            if (st_en && dmem_we !== 1'b1) begin
                other_errors++;
                $display("%0d ns: a store to %h was expected but the core did not write",
                         $time, st_addr);
            end else if (!st_en && dmem_we !== 1'b0) begin
                other_errors++;
                $display("%0d ns: the core wrote memory where no store was expected", $time);
            end else if (st_en) begin
                check_store(dmem_addr, dmem_wdata, st_addr, st_data);
            end
        end
        $display("errors: pc %0d, store %0d, other %0d", pc_errors, store_errors, other_errors);
        if (pc_errors + store_errors + other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial begin
        #((RESET_CYCLES + WATCHDOG_CYCLES) * CLK_PERIOD);
        $display("watchdog: the run did not end in time and was stopped");
        $display("TB FAILED");
        $finish;
    end

endmodule

/* rv_core_prog.hex */
// one instruction word per line, address 0 first
00002083
00402103
00802183
00208233
40320233
00321233
403152B3
00524233
0030D2B3
00526233
00227233
04402023
FFB08313
7FF34313
F0036313
FFD37313
00731313
41415393
00734333
00335313
04602223
ABCDE437
12345497
00940433
04802423
04802503
00150013
04002623
04A02823
FFF00593
00100613
00C58463
00C60463
00178793
00C61463
00C59463
00178793
00B64463
00C5C463
00178793
00C5D463
00B65463
00178793
00C5E463
00B66463
00178793
00B67463
00C5F463
00178793
008000EF
00178793
04102A23
0DD00693
00068767
00178793
04E02C23
0000006F

/* rv_core.f */
rv_pkg.sv
alu.sv
branch_unit.sv
imm_gen.sv
inst_decoder.sv
register_file.sv
pc_unit.sv
rv_core.sv
tb_clock_gen.sv
rv_core_assertions.sv
rv_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rv_core.f --top-module rv_core_tb -o rv_core_sim

status=0
./obj_dir/rv_core_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
